// ==== common/read_arb_consts.svh ====
// Cache read arbiter constants
// Widths of the memory port and the instruction cache refill line,
// plus the request sizes used when converting an instruction cache miss
`ifndef READ_ARB_CONSTS_SVH
`define READ_ARB_CONSTS_SVH

`define MEM_ADDR_WIDTH    32
`define MEM_ID_WIDTH      4
`define MEM_DATA_WIDTH    64
`define ICACHE_LINE_WIDTH 128
`define ICACHE_BEATS      2
`define NUM_READ_SRC      3

// log2 of bytes per transfer
`define ICACHE_WORD_SIZE  2
`define ICACHE_LINE_SIZE  3

`endif

// ==== common/read_arb_pkg.sv ====
// Cache read arbiter types
// Request, response and refill structures shared by the read arbiter
// and its requesters
`default_nettype none

`include "read_arb_consts.svh"

package read_arb_pkg;

  typedef struct packed {
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    logic                       len;
    logic [2:0]                 size;
    logic [`MEM_ID_WIDTH-1:0]   id;
    logic                       cacheable;
  } mem_req_t;

  typedef struct packed {
    logic [`MEM_ID_WIDTH-1:0]   id;
    logic [`MEM_DATA_WIDTH-1:0] data;
    logic                       error;
    logic                       last;
  } mem_resp_t;

  typedef struct packed {
    logic [`MEM_ADDR_WIDTH-1:0] paddr;
    logic                       nc;
    logic [`MEM_ID_WIDTH-1:0]   tid;
  } icache_req_t;

  typedef struct packed {
    logic [`ICACHE_LINE_WIDTH-1:0] data;
    logic [`MEM_ID_WIDTH-1:0]      tid;
  } icache_rtrn_t;

  // Refill line seen whole or beat by beat
  typedef union packed {
    logic [`ICACHE_LINE_WIDTH-1:0]                     line;
    logic [`ICACHE_BEATS-1:0][`MEM_DATA_WIDTH-1:0]     beats;
  } refill_line_u;

  // One-hot source select
  typedef logic [`NUM_READ_SRC-1:0] read_src_t;

endpackage

`default_nettype wire

// ==== icache/icache_miss_req_adapter.sv ====
// Instruction cache miss request adapter
// One-entry buffer that turns an instruction cache miss into a
// memory read request and holds it until arbitration takes it
`timescale 1ns/1ps
`default_nettype none

`include "read_arb_consts.svh"

module icache_miss_req_adapter
  import read_arb_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        miss_valid_i,
  output logic        miss_ready_o,
  input  icache_req_t miss_i,

  output logic        req_valid_o,
  input  logic        req_ready_i,
  output mem_req_t    req_o
);

  logic     full_q;
  mem_req_t req_q;
  mem_req_t req_d;

  // Line refill is a burst, uncached fetch is a single word
  always_comb begin
    req_d.addr      = miss_i.paddr;
    req_d.len       = miss_i.nc ? 1'b0 : 1'(`ICACHE_BEATS - 1);
    req_d.size      = miss_i.nc ? 3'(`ICACHE_WORD_SIZE) : 3'(`ICACHE_LINE_SIZE);
    req_d.id        = miss_i.tid;
    req_d.cacheable = ~miss_i.nc;
  end

  // Accept when empty or when the held request leaves this cycle
  assign miss_ready_o = ~full_q | req_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (miss_valid_i && miss_ready_o) begin
      full_q <= 1'b1;
    end else if (req_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_valid_i && miss_ready_o) begin
      req_q <= req_d;
    end
  end

  assign req_valid_o = full_q;
  assign req_o       = req_q;

endmodule

`default_nettype wire

// ==== icache/icache_refill_gather.sv ====
// Instruction cache refill gatherer
// Collects memory response beats into a full instruction cache line
// and returns it with the transaction ID as a one-cycle pulse
`timescale 1ns/1ps
`default_nettype none

`include "read_arb_consts.svh"

module icache_refill_gather
  import read_arb_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,

  input  logic         beat_valid_i,
  input  mem_resp_t    beat_i,

  output logic         rtrn_valid_o,
  output icache_rtrn_t rtrn_o
);

  localparam int CNT_W = $clog2(`ICACHE_BEATS);

  logic [CNT_W-1:0]        cnt_q;
  refill_line_u            line_q;
  refill_line_u            line_d;
  logic [`MEM_ID_WIDTH-1:0] tid_q;
  logic                    rtrn_valid_q;

  // First beat of a refill starts from an empty line
  // so a single-beat uncached return reads zero above beat 0
  always_comb begin
    line_d = line_q;
    if (cnt_q == '0) begin
      line_d.line = '0;
    end
    line_d.beats[cnt_q] = beat_i.data;
  end

  // Beat counter and return pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q        <= '0;
      rtrn_valid_q <= 1'b0;
    end else begin
      rtrn_valid_q <= beat_valid_i & beat_i.last;
      if (beat_valid_i) begin
        if (beat_i.last) begin
          cnt_q <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      line_q <= line_d;
    end
    if (beat_valid_i && beat_i.last) begin
      tid_q <= beat_i.id;
    end
  end

  assign rtrn_valid_o = rtrn_valid_q;
  assign rtrn_o.data  = line_q.line;
  assign rtrn_o.tid   = tid_q;

endmodule

`default_nettype wire

// ==== hdl/read_arb_ctrl.sv ====
// Read arbitration and routing controller
// Round-robin grant over the read sources with load control of the
// memory request register, and ID-based routing of read responses
`timescale 1ns/1ps
`default_nettype none

`include "read_arb_consts.svh"

module read_arb_ctrl
  import read_arb_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  read_src_t                src_valid_i,
  output read_src_t                src_ready_o,
  input  logic                     out_full_i,
  input  logic                     mem_req_ready_i,
  output read_src_t                grant_o,
  output logic                     load_o,

  input  logic [`MEM_ID_WIDTH-1:0] resp_id_i,
  input  logic [`MEM_ID_WIDTH-1:0] icache_id_i,
  input  logic [`MEM_ID_WIDTH-1:0] uc_read_id_i,
  output read_src_t                route_o
);

  localparam int IDX_W = $clog2(`NUM_READ_SRC);

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] win_idx;
  read_src_t        grant;
  logic             can_load;

  // First valid source at or after the pointer wins
  always_comb begin
    int unsigned idx;
    grant   = '0;
    win_idx = ptr_q;
    for (int unsigned i = 0; i < `NUM_READ_SRC; i++) begin
      idx = ptr_q + i;
      if (idx >= `NUM_READ_SRC) begin
        idx = idx - `NUM_READ_SRC;
      end
      if (grant == '0 && src_valid_i[idx]) begin
        grant[idx] = 1'b1;
        win_idx    = IDX_W'(idx);
      end
    end
  end

  // Output register free or draining this cycle
  assign can_load    = ~out_full_i | mem_req_ready_i;
  assign load_o      = can_load & (|src_valid_i);
  assign grant_o     = grant;
  assign src_ready_o = grant & {`NUM_READ_SRC{can_load}};

  // Pointer moves just past the winner
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (load_o) begin
      if (win_idx == IDX_W'(`NUM_READ_SRC - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + 1'b1;
      end
    end
  end

  // Unknown IDs belong to the data cache miss path
  always_comb begin
    if (resp_id_i == icache_id_i) begin
      route_o = read_src_t'(3'b001);
    end else if (resp_id_i == uc_read_id_i) begin
      route_o = read_src_t'(3'b100);
    end else begin
      route_o = read_src_t'(3'b010);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/read_req_mux.sv ====
// Read request multiplexer
// Selects the granted source request and holds it in the output
// register until memory accepts it
`timescale 1ns/1ps
`default_nettype none

`include "read_arb_consts.svh"

module read_req_mux
  import read_arb_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,

  input  mem_req_t [`NUM_READ_SRC-1:0]    req_i,
  input  read_src_t                       grant_i,
  input  logic                            load_i,

  input  logic                            mem_req_ready_i,
  output logic                            mem_req_valid_o,
  output mem_req_t                        mem_req_o,
  output logic                            full_o
);

  logic     full_q;
  mem_req_t req_q;
  mem_req_t req_sel;

  // AND-OR select on the one-hot grant
  always_comb begin
    req_sel = '0;
    for (int i = 0; i < `NUM_READ_SRC; i++) begin
      if (grant_i[i]) begin
        req_sel = req_sel | req_i[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (load_i) begin
      full_q <= 1'b1;
    end else if (mem_req_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      req_q <= req_sel;
    end
  end

  assign mem_req_valid_o = full_q;
  assign mem_req_o       = req_q;
  assign full_o          = full_q;

endmodule

`default_nettype wire

// ==== hdl/read_resp_demux.sv ====
// Read response demultiplexer
// Registers one memory response beat and offers it only to the
// destination selected by the routing controller
`timescale 1ns/1ps
`default_nettype none

`include "read_arb_consts.svh"

module read_resp_demux
  import read_arb_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     mem_resp_valid_i,
  output logic                     mem_resp_ready_o,
  input  mem_resp_t                mem_resp_i,

  input  read_src_t                route_i,
  output logic [`MEM_ID_WIDTH-1:0] held_id_o,

  output read_src_t                dst_valid_o,
  input  read_src_t                dst_ready_i,
  output mem_resp_t                dst_resp_o
);

  logic      full_q;
  mem_resp_t resp_q;
  logic      take;

  assign dst_valid_o = route_i & {`NUM_READ_SRC{full_q}};

  // Held beat leaves when its own destination is ready
  assign take             = |(dst_valid_o & dst_ready_i);
  assign mem_resp_ready_o = ~full_q | take;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (mem_resp_valid_i && mem_resp_ready_o) begin
      full_q <= 1'b1;
    end else if (take) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_resp_valid_i && mem_resp_ready_o) begin
      resp_q <= mem_resp_i;
    end
  end

  assign held_id_o  = resp_q.id;
  assign dst_resp_o = resp_q;

endmodule

`default_nettype wire

// ==== hdl/cache_read_arbiter.sv ====
// Cache subsystem read arbiter
// Shares one memory read port between the instruction cache miss path,
// the data cache miss path and the data cache uncached read path, and
// steers read responses back to their sources by ID
`timescale 1ns/1ps
`default_nettype none

`include "read_arb_consts.svh"

module cache_read_arbiter
  import read_arb_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     icache_miss_valid_i,
  output logic                     icache_miss_ready_o,
  input  icache_req_t              icache_miss_i,
  input  logic                     dcache_miss_valid_i,
  output logic                     dcache_miss_ready_o,
  input  mem_req_t                 dcache_miss_i,
  input  logic                     dcache_uc_read_valid_i,
  output logic                     dcache_uc_read_ready_o,
  input  mem_req_t                 dcache_uc_read_i,

  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output mem_req_t                 mem_req_o,
  input  logic                     mem_resp_valid_i,
  output logic                     mem_resp_ready_o,
  input  mem_resp_t                mem_resp_i,

  output logic                     icache_resp_valid_o,
  output icache_rtrn_t             icache_resp_o,
  output logic                     dcache_miss_resp_valid_o,
  input  logic                     dcache_miss_resp_ready_i,
  output mem_resp_t                dcache_miss_resp_o,
  output logic                     dcache_uc_read_resp_valid_o,
  input  logic                     dcache_uc_read_resp_ready_i,
  output mem_resp_t                dcache_uc_read_resp_o,

  input  logic [`MEM_ID_WIDTH-1:0] icache_miss_id_i,
  input  logic [`MEM_ID_WIDTH-1:0] dcache_uc_read_id_i
);

  logic                         ic_req_valid;
  mem_req_t                     ic_req;
  mem_req_t [`NUM_READ_SRC-1:0] src_req;
  read_src_t                    src_valid;
  read_src_t                    src_ready;
  read_src_t                    grant;
  logic                         load;
  logic                         out_full;
  read_src_t                    route;
  logic [`MEM_ID_WIDTH-1:0]     held_id;
  read_src_t                    dst_valid;
  read_src_t                    dst_ready;
  mem_resp_t                    dst_resp;

  icache_miss_req_adapter u_ic_adapter (
    .clk_i, .reset_i,
    .miss_valid_i (icache_miss_valid_i), .miss_ready_o (icache_miss_ready_o),
    .miss_i       (icache_miss_i),
    .req_valid_o  (ic_req_valid), .req_ready_i (src_ready[0]), .req_o (ic_req)
  );

  // Source order sets the round-robin order
  assign src_valid = {dcache_uc_read_valid_i, dcache_miss_valid_i, ic_req_valid};
  assign src_req   = {dcache_uc_read_i, dcache_miss_i, ic_req};
  assign dcache_miss_ready_o    = src_ready[1];
  assign dcache_uc_read_ready_o = src_ready[2];

  read_arb_ctrl u_ctrl (
    .clk_i, .reset_i,
    .src_valid_i (src_valid), .src_ready_o (src_ready), .out_full_i (out_full),
    .mem_req_ready_i, .grant_o (grant), .load_o (load),
    .resp_id_i   (held_id), .icache_id_i (icache_miss_id_i),
    .uc_read_id_i (dcache_uc_read_id_i), .route_o (route)
  );

  read_req_mux u_req_mux (
    .clk_i, .reset_i,
    .req_i (src_req), .grant_i (grant), .load_i (load),
    .mem_req_ready_i, .mem_req_valid_o, .mem_req_o, .full_o (out_full)
  );

  // Refill gatherer never stalls
  assign dst_ready = {dcache_uc_read_resp_ready_i, dcache_miss_resp_ready_i, 1'b1};

  read_resp_demux u_resp_demux (
    .clk_i, .reset_i,
    .mem_resp_valid_i, .mem_resp_ready_o, .mem_resp_i,
    .route_i (route), .held_id_o (held_id),
    .dst_valid_o (dst_valid), .dst_ready_i (dst_ready), .dst_resp_o (dst_resp)
  );

  icache_refill_gather u_gather (
    .clk_i, .reset_i,
    .beat_valid_i (dst_valid[0]), .beat_i (dst_resp),
    .rtrn_valid_o (icache_resp_valid_o), .rtrn_o (icache_resp_o)
  );

  assign dcache_miss_resp_valid_o    = dst_valid[1];
  assign dcache_miss_resp_o          = dst_resp;
  assign dcache_uc_read_resp_valid_o = dst_valid[2];
  assign dcache_uc_read_resp_o       = dst_resp;

endmodule

`default_nettype wire

// ==== tb/read_arb_properties.sv ====
// Handshake properties of the cache read arbiter
// Memory request stability, single destination valid, quiet after reset
`timescale 1ns/1ps
`default_nettype none

module read_arb_properties
  import read_arb_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input logic      mem_req_valid_o,
  input logic      mem_req_ready_i,
  input mem_req_t  mem_req_o,
  input read_src_t dst_valid_i,
  input logic      icache_resp_valid_o
);

  // Number of assertion failures so far
  int assert_fails = 0;

  // Request held until memory takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else begin
      assert_fails++;
      $error("memory request dropped or changed before acceptance");
    end

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(dst_valid_i))
    else begin
      assert_fails++;
      $error("more than one response destination valid");
    end

  assert property (@(posedge clk_i) $fell(reset_i) |->
    !mem_req_valid_o && dst_valid_i == '0 && !icache_resp_valid_o)
    else begin
      assert_fails++;
      $error("control output high right after reset");
    end

endmodule

bind cache_read_arbiter read_arb_properties u_props (
  .clk_i, .reset_i, .mem_req_valid_o, .mem_req_ready_i, .mem_req_o,
  .dst_valid_i (dst_valid), .icache_resp_valid_o
);

`default_nettype wire

// ==== tb/tb_cache_read_arbiter.sv ====
// Testbench for the cache read arbiter
// Feeds the three read sources, models memory with random ready delays
// and checks memory requests, data cache responses and refill lines
`timescale 1ns/1ps
`default_nettype none

`include "read_arb_consts.svh"

module tb_cache_read_arbiter
  import read_arb_pkg::*;
();

  localparam logic [3:0] IC_ID = 4'hA;
  localparam logic [3:0] UC_ID = 4'hC;

  logic clk_i, reset_i;
  logic icache_miss_valid_i, icache_miss_ready_o;
  icache_req_t icache_miss_i;
  logic dcache_miss_valid_i, dcache_miss_ready_o;
  mem_req_t dcache_miss_i;
  logic dcache_uc_read_valid_i, dcache_uc_read_ready_o;
  mem_req_t dcache_uc_read_i;
  logic mem_req_valid_o, mem_req_ready_i;
  mem_req_t mem_req_o;
  logic mem_resp_valid_i, mem_resp_ready_o;
  mem_resp_t mem_resp_i;
  logic icache_resp_valid_o;
  icache_rtrn_t icache_resp_o;
  logic dcache_miss_resp_valid_o, dcache_miss_resp_ready_i;
  mem_resp_t dcache_miss_resp_o;
  logic dcache_uc_read_resp_valid_o, dcache_uc_read_resp_ready_i;
  mem_resp_t dcache_uc_read_resp_o;
  logic [`MEM_ID_WIDTH-1:0] icache_miss_id_i, dcache_uc_read_id_i;

  icache_req_t ic_stim_q[$];
  mem_req_t dm_stim_q[$];
  mem_req_t uc_stim_q[$];
  mem_req_t exp_req_q[$];
  mem_resp_t exp_resp_q[$];
  icache_rtrn_t exp_rtrn_q[$];
  mem_req_t mem_q[$];
  mem_req_t cur_req;
  int beat_idx, errors, err_start, tests, failed, last_src, assert_seen;
  logic ic_fire, dm_fire, uc_fire, resp_fire, rnd_ready, alt_mode;
  logic [31:0] rng_state;
  string test_name;

  cache_read_arbiter uut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Memory contents as a function of address and beat index
  function automatic logic [63:0] beat_data(input logic [31:0] addr, input int k);
    return {~addr, addr + 32'(k) * 32'h0101};
  endfunction

  function automatic int dest_of(input logic [3:0] id);
    if (id == IC_ID) return 0;
    if (id == UC_ID) return 2;
    return 1;
  endfunction

  function automatic mem_req_t make_req(input logic [31:0] addr, input logic len,
                                        input logic [3:0] id);
    mem_req_t r;
    r.addr      = addr;
    r.len       = len;
    r.size      = len ? 3'd3 : 3'd2;
    r.id        = id;
    r.cacheable = len;
    return r;
  endfunction

  function automatic mem_resp_t resp_beat(input mem_req_t r, input int k);
    mem_resp_t b;
    b.id    = r.id;
    b.data  = beat_data(r.addr, k);
    b.error = 1'b0;
    b.last  = (k == int'(r.len));
    return b;
  endfunction

  // Expected memory request for an instruction cache miss
  function automatic mem_req_t ref_ic_req(input icache_req_t m);
    mem_req_t r;
    r.addr      = m.paddr;
    r.len       = m.nc ? 1'b0 : 1'b1;
    r.size      = m.nc ? 3'(`ICACHE_WORD_SIZE) : 3'(`ICACHE_LINE_SIZE);
    r.id        = m.tid;
    r.cacheable = ~m.nc;
    return r;
  endfunction

  // Expected refill line, uncached fetch fills only the low beat
  function automatic icache_rtrn_t ref_refill(input icache_req_t m);
    icache_rtrn_t r;
    r.tid  = m.tid;
    r.data = m.nc ? {64'h0, beat_data(m.paddr, 0)}
                  : {beat_data(m.paddr, 1), beat_data(m.paddr, 0)};
    return r;
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("[ERROR] %s: %s", test_name, msg);
  endtask

  task automatic check_mem_req(input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: mem_req expected %h actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_mem_resp(input mem_resp_t exp, input mem_resp_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: mem_resp expected %h actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_icache_rtrn(input icache_rtrn_t exp, input icache_rtrn_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: icache_rtrn expected %h actual %h", test_name, exp, act);
    end
  endtask

  // Oldest outstanding beat for this port
  task automatic match_resp(input int port, input mem_resp_t act);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_resp_q.size(); i++) begin
      if (idx < 0 && dest_of(exp_resp_q[i].id) == port) idx = i;
    end
    if (idx < 0) begin
      report_fail($sformatf("response on port %0d that nobody asked for", port));
    end else begin
      check_mem_resp(exp_resp_q[idx], act);
      exp_resp_q.delete(idx);
    end
  endtask

  // Checker, sampled on the rising edge
  always @(posedge clk_i) begin : monitor
    int idx;
    ic_fire   <= icache_miss_valid_i && icache_miss_ready_o;
    dm_fire   <= dcache_miss_valid_i && dcache_miss_ready_o;
    uc_fire   <= dcache_uc_read_valid_i && dcache_uc_read_ready_o;
    resp_fire <= mem_resp_valid_i && mem_resp_ready_o;
    if (!reset_i && mem_req_valid_o && mem_req_ready_i) begin
      mem_q.push_back(mem_req_o);
      idx = -1;
      for (int i = 0; i < exp_req_q.size(); i++) begin
        if (idx < 0 && dest_of(exp_req_q[i].id) == dest_of(mem_req_o.id)) idx = i;
      end
      if (idx < 0) begin
        report_fail("memory request that no source sent");
      end else begin
        check_mem_req(exp_req_q[idx], mem_req_o);
        exp_req_q.delete(idx);
      end
      if (alt_mode && dest_of(mem_req_o.id) == last_src) begin
        report_fail("same source won twice in a row");
      end
      last_src = dest_of(mem_req_o.id);
    end
    if (!reset_i && dcache_miss_resp_valid_o && dcache_miss_resp_ready_i) begin
      match_resp(1, dcache_miss_resp_o);
    end
    if (!reset_i && dcache_uc_read_resp_valid_o && dcache_uc_read_resp_ready_i) begin
      match_resp(2, dcache_uc_read_resp_o);
    end
    if (!reset_i && icache_resp_valid_o) begin
      if (exp_rtrn_q.size() == 0) begin
        report_fail("refill return pulse with no refill pending");
      end else begin
        check_icache_rtrn(exp_rtrn_q.pop_front(), icache_resp_o);
      end
    end
  end

  // Source feeders, memory model and ready delays
  always @(negedge clk_i) begin
    if (!reset_i) begin
      rng_state = xorshift(rng_state);
      mem_req_ready_i             <= ~rnd_ready | rng_state[0] | rng_state[1];
      dcache_miss_resp_ready_i    <= ~rnd_ready | rng_state[2] | rng_state[3];
      dcache_uc_read_resp_ready_i <= ~rnd_ready | rng_state[4];
      if (!icache_miss_valid_i || ic_fire) begin
        icache_miss_valid_i <= (ic_stim_q.size() > 0);
        if (ic_stim_q.size() > 0) icache_miss_i <= ic_stim_q.pop_front();
      end
      if (!dcache_miss_valid_i || dm_fire) begin
        dcache_miss_valid_i <= (dm_stim_q.size() > 0);
        if (dm_stim_q.size() > 0) dcache_miss_i <= dm_stim_q.pop_front();
      end
      if (!dcache_uc_read_valid_i || uc_fire) begin
        dcache_uc_read_valid_i <= (uc_stim_q.size() > 0);
        if (uc_stim_q.size() > 0) dcache_uc_read_i <= uc_stim_q.pop_front();
      end
      // Requests are answered in acceptance order, len+1 beats each
      if (!mem_resp_valid_i || resp_fire) begin
        if (mem_resp_valid_i && !mem_resp_i.last) begin
          beat_idx++;
          mem_resp_i <= resp_beat(cur_req, beat_idx);
        end else if (mem_q.size() > 0) begin
          cur_req = mem_q.pop_front();
          beat_idx = 0;
          mem_resp_i       <= resp_beat(cur_req, 0);
          mem_resp_valid_i <= 1'b1;
        end else begin
          mem_resp_valid_i <= 1'b0;
        end
      end
    end
  end

  task automatic send_ic(input logic [31:0] addr, input logic nc);
    icache_req_t m;
    m.paddr = addr;
    m.nc    = nc;
    m.tid   = IC_ID;
    ic_stim_q.push_back(m);
    exp_req_q.push_back(ref_ic_req(m));
    exp_rtrn_q.push_back(ref_refill(m));
  endtask

  task automatic send_dc(input int src, input mem_req_t r);
    if (src == 1) dm_stim_q.push_back(r);
    else uc_stim_q.push_back(r);
    exp_req_q.push_back(r);
    for (int k = 0; k <= int'(r.len); k++) exp_resp_q.push_back(resp_beat(r, k));
  endtask

  // Tests start on a rising edge so the feeders pick them up at the next falling edge
  task automatic start_test(input string name);
    @(posedge clk_i);
    test_name = name;
    err_start = errors;
    last_src  = -1;
  endtask

  // Waits until every expected transfer was seen
  task automatic finish_test(input int max_cycles);
    int n;
    n = 0;
    while ((exp_req_q.size() + exp_resp_q.size() + exp_rtrn_q.size()) != 0
           && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= max_cycles) begin
      report_fail("timed out waiting for outstanding transfers");
      exp_req_q.delete();
      exp_resp_q.delete();
      exp_rtrn_q.delete();
    end
    if (uut.u_props.assert_fails != assert_seen) begin
      report_fail("a handshake assertion failed during the test");
      assert_seen = uut.u_props.assert_fails;
    end
    tests++;
    if (errors != err_start) failed++;
    $display("test %s: %s", test_name, (errors == err_start) ? "ok" : "failed");
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    {icache_miss_valid_i, dcache_miss_valid_i, dcache_uc_read_valid_i} = '0;
    icache_miss_i = '0;
    dcache_miss_i = '0;
    dcache_uc_read_i = '0;
    {mem_req_ready_i, dcache_miss_resp_ready_i, dcache_uc_read_resp_ready_i} = '1;
    mem_resp_valid_i = 1'b0;
    mem_resp_i = '0;
    icache_miss_id_i = IC_ID;
    dcache_uc_read_id_i = UC_ID;
    {ic_fire, dm_fire, uc_fire, resp_fire, rnd_ready, alt_mode} = '0;
    rng_state = 32'd64095;
    {errors, tests, failed, beat_idx, assert_seen} = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i <= 1'b0;

    start_test("dcache_passthrough");
    send_dc(1, make_req(32'h0000_1000, 1'b1, 4'h3));
    send_dc(2, make_req(32'h0000_2004, 1'b0, UC_ID));
    finish_test(200);
    start_test("icache_line_refill");
    send_ic(32'h0000_3040, 1'b0);
    finish_test(200);
    start_test("icache_uncached_word");
    send_ic(32'h0000_3104, 1'b1);
    finish_test(200);

    start_test("round_robin_alternation");
    alt_mode = 1'b1;
    for (int i = 0; i < 4; i++) begin
      send_dc(1, make_req(32'h0000_5000 + 32'(i) * 32'h40, 1'b0, 4'(i)));
      send_dc(2, make_req(32'h0000_5800 + 32'(i) * 4, 1'b0, UC_ID));
    end
    finish_test(400);
    alt_mode = 1'b0;

    start_test("random_backpressure");
    rnd_ready = 1'b1;
    for (int i = 0; i < 16; i++) begin
      case (i % 4)
        0: send_dc(1, make_req(32'h0000_4000 + 32'(i) * 32'h40, 1'b1, 4'(i % 8)));
        1: send_dc(2, make_req(32'h0000_8000 + 32'(i) * 4, 1'b0, UC_ID));
        2: send_ic(32'h0000_C000 + 32'(i) * 32'h40, i[3]);
        default: send_dc(1, make_req(32'h0000_6000 + 32'(i) * 8, 1'b0, 4'(i % 8)));
      endcase
    end
    finish_test(3000);

    $display("%0d tests run, %0d failed, %0d check errors", tests, failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/read_arb_pkg.sv
icache/icache_miss_req_adapter.sv
icache/icache_refill_gather.sv
hdl/read_arb_ctrl.sv
hdl/read_req_mux.sv
hdl/read_resp_demux.sv
hdl/cache_read_arbiter.sv
tb/read_arb_properties.sv
tb/tb_cache_read_arbiter.sv
